// File: rtl/lock_pkg.sv
package lock_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // keypad geometry
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int DIGIT_W      = 4;
  localparam int ENTRY_DIGITS = 12;  // digit 0 is the latest key
  localparam int CODE_DIGITS  = 8;   // codes are 4 to 8 digits
  localparam int NUM_CODES    = 4;
  localparam int FAIL_W       = 3;
  localparam int MAX_FAILS    = 5;   // failures before lockout

  typedef logic [DIGIT_W-1:0] digit_t;

  localparam digit_t DIGIT_FILL = 4'hF;  // pads short codes at the top
  localparam digit_t DIGIT_ERR  = 4'hE;  // keypad aborted the entry

  typedef struct packed {
    digit_t [ENTRY_DIGITS-1:0] digits;
  } key_entry_t;

  typedef struct packed {
    digit_t [CODE_DIGITS-1:0] digits;
  } user_code_t;

  typedef struct packed {
    user_code_t [NUM_CODES-1:0] code;
  } code_set_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // controller
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef struct packed {
    logic              bolt;       // door locked
    logic              beep;
    logic              keypad_en;
    logic              lockout;
    logic [FAIL_W-1:0] fail_count;
  } lock_status_t;

  typedef enum logic [3:0] {
    st_boot,
    st_locked,
    st_checking,
    st_closed_unlocked,
    st_open,
    st_open_alarm,
    st_fail_wait,
    st_lockout,
    st_error_beep
  } lock_state_t;

endpackage

// File: rtl/code_matcher.sv
`timescale 1ns/100ps

module code_matcher (
  input  logic                 clk,
  input  logic                 rst,
  input  lock_pkg::key_entry_t entry,
  input  logic                 entry_valid,
  input  lock_pkg::code_set_t  codes,
  output logic                 match_valid,
  output logic                 match_hit
);
  import lock_pkg::*;

  // entry padded with filler so every window stays in range
  localparam int EXT_DIGITS = ENTRY_DIGITS + CODE_DIGITS;

  typedef digit_t [EXT_DIGITS-1:0] ext_entry_t;

  ext_entry_t           ext;
  logic [NUM_CODES-1:0] code_hit;
  logic                 any_hit;

  // length is the position of the first filler digit
  function automatic int code_len(user_code_t code);
    int len;
    len = CODE_DIGITS;
    for (int i = CODE_DIGITS - 1; i >= 0; i--) begin
      if (code.digits[i] == DIGIT_FILL) begin
        len = i;
      end
    end
    return len;
  endfunction

  // slide the code over every offset of the entry
  function automatic logic code_found(ext_entry_t e, user_code_t code);
    int   len;
    logic ok;
    logic found;
    len   = code_len(code);
    found = 1'b0;
    for (int off = 0; off < ENTRY_DIGITS; off++) begin
      ok = (len > 0) && (off + len <= ENTRY_DIGITS);  // window fits inside entry
      for (int j = 0; j < CODE_DIGITS; j++) begin
        if (j < len && e[off + j] != code.digits[j]) begin
          ok = 1'b0;
        end
      end
      found = found | ok;
    end
    return found;
  endfunction

  assign ext = {{CODE_DIGITS{DIGIT_FILL}}, entry.digits};

  always_comb begin
    for (int c = 0; c < NUM_CODES; c++) begin
      code_hit[c] = code_found(ext, codes.code[c]);
    end
  end

  assign any_hit = |code_hit;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      match_valid <= 1'b0;
    end else begin
      match_valid <= entry_valid;  // fixed one cycle latency
    end
  end

  always_ff @(posedge clk) begin
    match_hit <= any_hit;
  end

  a_match_latency: assert property (@(posedge clk) disable iff (rst)
    entry_valid |=> match_valid);

endmodule

// File: rtl/button_debouncer.sv
`timescale 1ns/100ps

module button_debouncer #(
  parameter int DEBOUNCE_CYCLES = 100
) (
  input  logic clk,
  input  logic rst,
  input  logic inner_button,
  output logic press
);

  localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

  logic [CNT_W-1:0] hold_cnt;
  logic             fired;  // pulse already given for this hold

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // hold qualification
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      hold_cnt <= '0;
      fired    <= 1'b0;
      press    <= 1'b0;
    end else if (!inner_button) begin
      hold_cnt <= '0;  // any release restarts the hold
      fired    <= 1'b0;
      press    <= 1'b0;
    end else begin
      press <= 1'b0;
      if (!fired) begin
        if (hold_cnt == CNT_W'(DEBOUNCE_CYCLES - 1)) begin
          press <= 1'b1;
          fired <= 1'b1;
        end else begin
          hold_cnt <= hold_cnt + 1'b1;
        end
      end
    end
  end

  a_single_pulse: assert property (@(posedge clk) disable iff (rst)
    press |=> !press);

endmodule

// File: rtl/door_controller.sv
`timescale 1ns/100ps

module door_controller #(
  parameter int AUTO_LOCK_CYCLES = 5000,
  parameter int ALARM_CYCLES     = 3000,
  parameter int BEEP_CYCLES      = 50,
  parameter int FAIL_WAIT_CYCLES = 1000,
  parameter int LOCKOUT_CYCLES   = 30000
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   door_open,
  input  lock_pkg::digit_t       entry_digit0,
  input  logic                   entry_valid,
  input  logic                   match_valid,
  input  logic                   match_hit,
  input  logic                   press,
  output lock_pkg::lock_status_t status
);
  import lock_pkg::*;

  // one shared timer, sized for the longest period
  localparam int MAX_A   = (AUTO_LOCK_CYCLES > ALARM_CYCLES) ? AUTO_LOCK_CYCLES : ALARM_CYCLES;
  localparam int MAX_B   = (BEEP_CYCLES > FAIL_WAIT_CYCLES) ? BEEP_CYCLES : FAIL_WAIT_CYCLES;
  localparam int MAX_C   = (MAX_A > MAX_B) ? MAX_A : MAX_B;
  localparam int MAX_T   = (MAX_C > LOCKOUT_CYCLES) ? MAX_C : LOCKOUT_CYCLES;
  localparam int TIMER_W = $clog2(MAX_T + 1);

  lock_state_t        state_q;
  lock_state_t        state_d;
  logic [TIMER_W-1:0] timer;
  logic [FAIL_W-1:0]  fail_count;

  logic auto_lock_done;
  logic alarm_done;
  logic beep_done;
  logic fail_wait_done;
  logic lockout_done;
  logic key_err;
  logic miss;

  assign auto_lock_done = (timer >= TIMER_W'(AUTO_LOCK_CYCLES - 1));
  assign alarm_done     = (timer >= TIMER_W'(ALARM_CYCLES - 1));
  assign beep_done      = (timer >= TIMER_W'(BEEP_CYCLES - 1));
  assign fail_wait_done = (timer >= TIMER_W'(FAIL_WAIT_CYCLES - 1));
  assign lockout_done   = (timer >= TIMER_W'(LOCKOUT_CYCLES - 1));

  assign key_err = (entry_digit0 == DIGIT_ERR);
  assign miss    = (state_q == st_checking) && match_valid && !match_hit;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // next state
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    state_d = state_q;
    case (state_q)
      st_boot: begin
        if (!door_open) begin
          state_d = st_locked;
        end
      end
      st_locked: begin
        if (entry_valid && key_err) begin
          state_d = st_error_beep;
        end else if (entry_valid) begin
          state_d = st_checking;  // result arrives next cycle
        end else if (press) begin
          state_d = st_closed_unlocked;
        end
      end
      st_checking: begin
        if (match_valid) begin
          state_d = match_hit ? st_closed_unlocked : st_fail_wait;
        end
      end
      st_closed_unlocked: begin
        if (door_open) begin
          state_d = st_open;
        end else if (press || auto_lock_done) begin
          state_d = st_locked;
        end
      end
      st_open: begin
        if (!door_open) begin
          state_d = st_closed_unlocked;
        end else if (alarm_done) begin
          state_d = st_open_alarm;
        end
      end
      st_open_alarm: begin
        if (!door_open) begin
          state_d = st_closed_unlocked;  // restarts auto relock
        end
      end
      st_fail_wait: begin
        if (fail_wait_done) begin
          state_d = (fail_count >= FAIL_W'(MAX_FAILS)) ? st_lockout : st_locked;
        end
      end
      st_lockout: begin
        if (lockout_done) begin
          state_d = st_locked;
        end
      end
      st_error_beep: begin
        if (beep_done) begin
          state_d = st_locked;
        end
      end
      default: state_d = st_boot;
    endcase
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // state, timer and failure count
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state_q    <= st_boot;
      timer      <= '0;
      fail_count <= '0;
    end else begin
      state_q <= state_d;
      if (state_d != state_q) begin
        timer <= '0;  // every timed state starts from zero
      end else begin
        timer <= timer + 1'b1;
      end
      if (miss) begin
        fail_count <= fail_count + 1'b1;
      end else if (state_q == st_lockout && lockout_done) begin
        fail_count <= '0;
      end
    end
  end

  always_comb begin
    status.bolt       = state_q inside {st_locked, st_checking, st_fail_wait,
                                        st_lockout, st_error_beep};
    status.beep       = state_q inside {st_error_beep, st_open_alarm};
    status.keypad_en  = (state_q == st_locked);
    status.lockout    = (state_q == st_lockout);
    status.fail_count = fail_count;
  end

  a_bolt_door: assert property (@(posedge clk) disable iff (rst)
    !(status.bolt && door_open));

  a_fail_limit: assert property (@(posedge clk) disable iff (rst)
    fail_count <= FAIL_W'(MAX_FAILS));

endmodule

// File: rtl/door_lock_top.sv
`timescale 1ns/100ps

module door_lock_top #(
  parameter int AUTO_LOCK_CYCLES = 5000,
  parameter int DEBOUNCE_CYCLES  = 100,
  parameter int ALARM_CYCLES     = 3000,
  parameter int BEEP_CYCLES      = 50,
  parameter int FAIL_WAIT_CYCLES = 1000,
  parameter int LOCKOUT_CYCLES   = 30000
) (
  input  logic                   clk,
  input  logic                   rst,
  input  lock_pkg::key_entry_t   entry,
  input  logic                   entry_valid,
  input  lock_pkg::code_set_t    codes,
  input  logic                   door_open,
  input  logic                   inner_button,
  output lock_pkg::lock_status_t status
);

  logic match_valid;
  logic match_hit;
  logic press;

  code_matcher code_matcher_inst (
    .clk         (clk),
    .rst         (rst),
    .entry       (entry),
    .entry_valid (entry_valid),
    .codes       (codes),
    .match_valid (match_valid),
    .match_hit   (match_hit)
  );

  button_debouncer #(
    .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
  ) button_debouncer_inst (
    .clk          (clk),
    .rst          (rst),
    .inner_button (inner_button),
    .press        (press)
  );

  door_controller #(
    .AUTO_LOCK_CYCLES (AUTO_LOCK_CYCLES),
    .ALARM_CYCLES     (ALARM_CYCLES),
    .BEEP_CYCLES      (BEEP_CYCLES),
    .FAIL_WAIT_CYCLES (FAIL_WAIT_CYCLES),
    .LOCKOUT_CYCLES   (LOCKOUT_CYCLES)
  ) door_controller_inst (
    .clk          (clk),
    .rst          (rst),
    .door_open    (door_open),
    .entry_digit0 (entry.digits[0]),  // error digit check
    .entry_valid  (entry_valid),
    .match_valid  (match_valid),
    .match_hit    (match_hit),
    .press        (press),
    .status       (status)
  );

endmodule

// File: testbench/door_lock_cases.svh
`ifndef DOOR_LOCK_CASES_SVH
`define DOOR_LOCK_CASES_SVH

// columns: entry (digit 0 rightmost), random digit mask, {entry_valid, door_open,
// inner_button, model}, hold cycles, {bolt, beep, keypad_en, lockout}, fail_count

typedef struct packed {
  logic [ENTRY_DIGITS*DIGIT_W-1:0] entry;
  logic [ENTRY_DIGITS-1:0]         rand_mask;  // digits replaced by random ones
  logic [3:0]                      ctl;
  logic [7:0]                      hold;
  logic [3:0]                      flags;      // ignored on model rows
  logic [2:0]                      fail;
} step_t;

localparam int NUM_STEPS = 27;

localparam step_t STEPS [NUM_STEPS] = '{
  {48'h000000000000, 12'h000, 4'b0000, 8'd3,  4'b1010, 3'd0},  // boot to locked
  {48'h000004321000, 12'hF86, 4'b1001, 8'd2,  4'b0000, 3'd0},  // code 0 hidden
  {48'h000000000000, 12'h000, 4'b0000, 8'd23, 4'b1010, 3'd0},  // auto relock
  {48'h000000000000, 12'h000, 4'b0010, 8'd4,  4'b1010, 3'd0},  // short press
  {48'h000000000000, 12'h000, 4'b0000, 8'd3,  4'b1010, 3'd0},
  {48'h000000000000, 12'h000, 4'b0010, 8'd9,  4'b0000, 3'd0},  // press unlocks
  {48'h000000000000, 12'h000, 4'b0000, 8'd3,  4'b0000, 3'd0},
  {48'h000000000000, 12'h000, 4'b0010, 8'd9,  4'b1010, 3'd0},  // press relocks
  {48'h000000000000, 12'h000, 4'b0000, 8'd3,  4'b1010, 3'd0},
  {48'h008765432100, 12'hC02, 4'b1001, 8'd2,  4'b0000, 3'd0},  // code 1 hidden
  {48'h000000000000, 12'h000, 4'b0100, 8'd3,  4'b0000, 3'd0},  // door opens
  {48'h000000000000, 12'h000, 4'b0100, 8'd13, 4'b0100, 3'd0},  // open too long
  {48'h000000000000, 12'h000, 4'b0000, 8'd3,  4'b0000, 3'd0},  // closed, quiet
  {48'h000000000000, 12'h000, 4'b0000, 8'd20, 4'b1010, 3'd0},
  {48'h000000001239, 12'h000, 4'b1001, 8'd2,  4'b0000, 3'd0},  // miss 1
  {48'h000000000000, 12'h000, 4'b0000, 8'd7,  4'b1010, 3'd1},
  {48'h00000000123E, 12'h000, 4'b1000, 8'd2,  4'b1100, 3'd1},  // broken entry
  {48'h000000000000, 12'h000, 4'b0000, 8'd7,  4'b1010, 3'd1},
  {48'h000000001234, 12'h000, 4'b1001, 8'd2,  4'b0000, 3'd0},  // miss 2
  {48'h000000000000, 12'h000, 4'b0000, 8'd7,  4'b1010, 3'd2},
  {48'h000000004320, 12'h000, 4'b1001, 8'd2,  4'b0000, 3'd0},  // miss 3
  {48'h000000000000, 12'h000, 4'b0000, 8'd7,  4'b1010, 3'd3},
  {48'h000000000A58, 12'h000, 4'b1001, 8'd2,  4'b0000, 3'd0},  // miss 4
  {48'h000000000000, 12'h000, 4'b0000, 8'd7,  4'b1010, 3'd4},
  {48'h999999999999, 12'h000, 4'b1001, 8'd2,  4'b0000, 3'd0},  // miss 5
  {48'h000000000000, 12'h000, 4'b0000, 8'd7,  4'b1001, 3'd5},  // lockout
  {48'h000000000000, 12'h000, 4'b0000, 8'd18, 4'b1010, 3'd0}   // count cleared
};

`endif

// File: testbench/door_lock_tb.sv
`timescale 1ns/100ps

module door_lock_tb;
  import lock_pkg::*;

  localparam int AUTO_LOCK_CYCLES = 20;
  localparam int DEBOUNCE_CYCLES  = 6;
  localparam int ALARM_CYCLES     = 10;
  localparam int BEEP_CYCLES      = 5;
  localparam int FAIL_WAIT_CYCLES = 4;
  localparam int LOCKOUT_CYCLES   = 16;
  localparam int RESET_CYCLES     = 8;

  `include "door_lock_cases.svh"

  logic         clk;
  logic         rst;
  key_entry_t   entry;
  logic         entry_valid;
  code_set_t    codes;
  logic         door_open;
  logic         inner_button;
  lock_status_t status;

  int          errors;
  int          checks;
  int          cycles;
  int          cycle_limit;
  logic [15:0] lfsr;
  logic [2:0]  fail_track;  // count the lock should hold now

  door_lock_top #(
    .AUTO_LOCK_CYCLES (AUTO_LOCK_CYCLES),
    .DEBOUNCE_CYCLES  (DEBOUNCE_CYCLES),
    .ALARM_CYCLES     (ALARM_CYCLES),
    .BEEP_CYCLES      (BEEP_CYCLES),
    .FAIL_WAIT_CYCLES (FAIL_WAIT_CYCLES),
    .LOCKOUT_CYCLES   (LOCKOUT_CYCLES)
  ) door_lock_top_inst (
    .clk          (clk),
    .rst          (rst),
    .entry        (entry),
    .entry_valid  (entry_valid),
    .codes        (codes),
    .door_open    (door_open),
    .inner_button (inner_button),
    .status       (status)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycle_limit > 0 && cycles > cycle_limit) begin
      $display("timeout: the steps did not finish within %0d cycles", cycle_limit);
      $display("** FAIL **");
      $finish;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // random digits and reference model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 16'hB400;  // galois taps 16,14,13,11
    end
    return s >> 1;
  endfunction

  task automatic take_random_digit(output digit_t d);
    d = '0;
    for (int b = 0; b < DIGIT_W; b++) begin
      d    = {d[DIGIT_W-2:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
  endtask

  // any code found as adjacent digits anywhere in the entry
  function automatic logic code_in_entry(input key_entry_t e, input code_set_t cs);
    int   len;
    logic same;
    logic found;
    found = 1'b0;
    for (int c = 0; c < NUM_CODES; c++) begin
      len = 0;
      while (len < CODE_DIGITS && cs.code[c].digits[len] != DIGIT_FILL) begin
        len++;
      end
      for (int s = 0; s + len <= ENTRY_DIGITS; s++) begin
        same = 1'b1;
        for (int j = 0; j < len; j++) begin
          if (e.digits[s + j] != cs.code[c].digits[j]) begin
            same = 1'b0;
          end
        end
        found = found | same;
      end
    end
    return found;
  endfunction

  function automatic int total_hold();
    int sum;
    sum = 0;
    for (int i = 0; i < NUM_STEPS; i++) begin
      sum += int'(STEPS[i].hold);
    end
    return sum;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // driver and checks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic check_field(input string name, input int got, input int want, input int idx);
    lock_state_t st;
    st = door_lock_top_inst.door_controller_inst.state_q;
    checks++;
    assert (got == want) else begin
      errors++;
      $display("** Error at %0d ns: %s = %0d, expected %0d (step %0d, state %s)",
               $time, name, got, want, idx, st.name());
    end
  endtask

  task automatic run_step(input int idx);
    step_t      s;
    key_entry_t e;
    digit_t     d;
    logic       hit;
    logic [3:0] want;
    logic [2:0] want_fail;
    s = STEPS[idx];
    e = s.entry;
    for (int i = 1; i < ENTRY_DIGITS; i++) begin
      if (s.rand_mask[i]) begin
        take_random_digit(d);
        e.digits[i] = d;
      end
    end
    entry        = e;
    entry_valid  = s.ctl[3];  // one cycle pulse
    door_open    = s.ctl[2];
    inner_button = s.ctl[1];
    @(posedge clk);
    #1;
    entry_valid = 1'b0;
    repeat (int'(s.hold) - 1) begin
      @(posedge clk);
      #1;
    end
    if (s.ctl[0]) begin
      hit       = code_in_entry(e, codes);
      want      = {!hit, 3'b000};  // unlocked on a hit, else waiting after a failure
      want_fail = hit ? fail_track : fail_track + 3'd1;
    end else begin
      want      = s.flags;
      want_fail = s.fail;
    end
    check_field("status.bolt", status.bolt, want[3], idx);
    check_field("status.beep", status.beep, want[2], idx);
    check_field("status.keypad_en", status.keypad_en, want[1], idx);
    check_field("status.lockout", status.lockout, want[0], idx);
    check_field("status.fail_count", status.fail_count, want_fail, idx);
    fail_track = want_fail;
  endtask

  initial begin
    clk            = 1'b0;
    rst            = 1'b1;
    entry          = '0;
    entry_valid    = 1'b0;
    door_open      = 1'b0;
    inner_button   = 1'b0;
    codes.code[0]  = 32'hFFFF4321;  // 4 digits
    codes.code[1]  = 32'h87654321;  // 8 digits
    codes.code[2]  = 32'hFF960A58;
    codes.code[3]  = 32'hFFF70707;
    errors         = 0;
    checks         = 0;
    cycles         = 0;
    lfsr           = 16'h0001;
    fail_track     = '0;
    cycle_limit    = RESET_CYCLES + total_hold() + 100;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst = 1'b0;
    for (int i = 0; i < NUM_STEPS; i++) begin
      run_step(i);
    end
    $display("steps: %0d, checks: %0d, errors: %0d", NUM_STEPS, checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// File: build.f
+incdir+testbench
rtl/lock_pkg.sv
rtl/code_matcher.sv
rtl/button_debouncer.sv
rtl/door_controller.sv
rtl/door_lock_top.sv
testbench/door_lock_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f build.f \
  --top-module door_lock_tb -Mdir obj_dir -o door_lock_sim

if ! ./obj_dir/door_lock_sim > sim.log 2>&1; then
  cat sim.log
  echo "simulation exited with an error"
  exit 1
fi

cat sim.log
if grep -q "\*\* FAIL \*\*" sim.log; then
  exit 1
fi
